// ==== rtl/cpu_macros.svh ====
// core widths and address map
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

`define ADDR_LEN 32
`define DATA_LEN 32
`define REG_LEN 5

// fetch starts here after reset
`define RESET_PC 32'h0000_0000

// I/O space has addr[17:16] == 2'b11
`define IO_OUT_ADDR 32'h0003_0000
`define IO_HALT_ADDR 32'h0003_0004

`endif

// ==== rtl/cpu_pkg.sv ====
// core types
`default_nettype none

package cpu_pkg;
  `include "cpu_macros.svh"

  // supported subset, everything else is a nop
  typedef enum logic [2:0] {
    OP_NOP,
    OP_LUI,
    OP_ADDI,
    OP_ADD,
    OP_SUB,
    OP_LW,
    OP_SW,
    OP_BEQ
  } op_e;

  typedef struct packed {
    op_e                  op;
    logic [`REG_LEN-1:0]  rd;
    logic [`REG_LEN-1:0]  rs1;
    logic [`REG_LEN-1:0]  rs2;
    logic [`DATA_LEN-1:0] imm;
  } decoded_t;

  typedef enum logic [1:0] {EX_IDLE, EX_MEM, EX_HALT} exec_state_e;

  typedef enum logic [1:0] {MC_IDLE, MC_BYTE, MC_LAST} mc_state_e;
endpackage

`default_nettype wire

// ==== rtl/mem_req_if.sv ====
// word request channel
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

interface mem_req_if;
  logic                 valid;
  logic                 ready;
  logic [`ADDR_LEN-1:0] addr;
  logic [`DATA_LEN-1:0] wdata;
  logic                 wr;
  logic                 done;
  // valid together with done on a read
  logic [`DATA_LEN-1:0] rdata;

  modport requester (
    output valid, addr, wdata, wr,
    input  ready, done, rdata
  );

  modport ctrl (
    input  valid, addr, wdata, wr,
    output ready, done, rdata
  );
endinterface

`default_nettype wire

// ==== rtl/inst_if.sv ====
// fetched instruction channel
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

interface inst_if;
  logic                 valid;
  logic                 ready;
  logic [`DATA_LEN-1:0] inst;
  logic [`ADDR_LEN-1:0] pc;

  modport source (output valid, inst, pc, input ready);
  modport sink (input valid, inst, pc, output ready);
endinterface

`default_nettype wire

// ==== rtl/mem_ctrl.sv ====
// memory controller
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module mem_ctrl
  import cpu_pkg::*;
(
  input  logic                 clk_in,
  input  logic                 rst_in,
  input  logic                 rdy_in,
  mem_req_if.ctrl              if_port,
  mem_req_if.ctrl              ls_port,
  input  logic [7:0]           mem_din,
  output logic [7:0]           mem_dout,
  output logic [`ADDR_LEN-1:0] mem_a,
  output logic                 mem_wr,
  input  logic                 io_buffer_full
);
  mc_state_e            state;
  logic [1:0]           cnt;
  logic                 src_ls;
  logic                 wr_q;
  logic [23:0]          wdata_q;
  logic [23:0]          rdata_q;
  logic                 samp_q;
  logic [7:0]           din_q;
  logic                 io_wait;
  logic                 stall;
  logic                 accept;
  logic                 done;
  logic [7:0]           byte_in;
  logic [`DATA_LEN-1:0] wdata_sel;

  // output byte held back while the uart is full
  assign io_wait = wr_q && (mem_a == `IO_OUT_ADDR) && io_buffer_full;
  assign stall = !rdy_in || io_wait;
  assign mem_wr = wr_q && !io_wait;

  // load/store side wins over fetch
  assign accept = (state == MC_IDLE) && rdy_in && (ls_port.valid || if_port.valid);
  assign ls_port.ready = accept && ls_port.valid;
  assign if_port.ready = accept && !ls_port.valid;
  assign wdata_sel = ls_port.valid ? ls_port.wdata : if_port.wdata;

  // byte for the previous address, kept aside if a pause hid it
  assign byte_in = samp_q ? mem_din : din_q;

  assign done = !stall && ((state == MC_LAST) ||
                           ((state == MC_BYTE) && (cnt == 2'd3) && wr_q));
  assign ls_port.done = done && src_ls;
  assign if_port.done = done && !src_ls;
  assign ls_port.rdata = {byte_in, rdata_q};
  assign if_port.rdata = {byte_in, rdata_q};

  always_ff @(posedge clk_in)
  begin
    if (rst_in)
    begin
      state  <= MC_IDLE;
      cnt    <= 2'd0;
      src_ls <= 1'b0;
      wr_q   <= 1'b0;
      mem_a  <= '0;
      samp_q <= 1'b0;
    end
    else
    begin
      samp_q <= rdy_in;
      if (!stall)
      begin
        case (state)
          MC_IDLE:
          begin
            if (accept)
            begin
              state  <= MC_BYTE;
              cnt    <= 2'd0;
              src_ls <= ls_port.valid;
              mem_a  <= ls_port.valid ? ls_port.addr : if_port.addr;
              wr_q   <= ls_port.valid ? ls_port.wr : if_port.wr;
            end
          end
          MC_BYTE:
          begin
            if (cnt == 2'd3)
            begin
              // a read waits one more cycle for its last byte
              state <= wr_q ? MC_IDLE : MC_LAST;
              wr_q  <= 1'b0;
            end
            else
            begin
              cnt   <= cnt + 2'd1;
              mem_a <= mem_a + `ADDR_LEN'(1);
            end
          end
          default:
            state <= MC_IDLE;
        endcase
      end
    end
  end

  // little-endian byte shifters
  always_ff @(posedge clk_in)
  begin
    if (!rdy_in && samp_q)
      din_q <= mem_din;
    if (accept)
    begin
      mem_dout <= wdata_sel[7:0];
      wdata_q  <= wdata_sel[31:8];
    end
    else if (!stall && (state == MC_BYTE))
    begin
      mem_dout <= wdata_q[7:0];
      wdata_q  <= {8'h00, wdata_q[23:8]};
      if (cnt != 2'd0)
        rdata_q <= {byte_in, rdata_q[23:8]};
    end
  end
endmodule

`default_nettype wire

// ==== rtl/fetcher.sv ====
// instruction fetcher
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module fetcher
  import cpu_pkg::*;
(
  input  logic                 clk_in,
  input  logic                 rst_in,
  input  logic                 rdy_in,
  mem_req_if.requester         mem,
  inst_if.source               inst,
  input  logic                 redirect,
  input  logic [`ADDR_LEN-1:0] redirect_pc
);
  logic                 req_q;
  logic                 wait_q;
  logic                 drop_q;
  logic                 out_q;
  logic [`ADDR_LEN-1:0] pc_q;
  logic [`ADDR_LEN-1:0] npc_q;
  logic [`DATA_LEN-1:0] inst_q;
  logic                 got;
  logic                 busy;
  logic                 take;

  assign got = wait_q && mem.done;
  // a fetch is still owed by the controller
  assign busy = req_q || (wait_q && !mem.done);
  assign take = inst.valid && inst.ready;

  assign mem.valid = req_q;
  assign mem.addr = pc_q;
  assign mem.wdata = '0;
  assign mem.wr = 1'b0;

  assign inst.valid = out_q;
  assign inst.inst = inst_q;
  assign inst.pc = pc_q;

  always_ff @(posedge clk_in)
  begin
    if (rst_in)
    begin
      req_q  <= 1'b0;
      wait_q <= 1'b0;
      drop_q <= 1'b0;
      out_q  <= 1'b0;
      pc_q   <= `RESET_PC;
    end
    else if (rdy_in)
    begin
      if (req_q && mem.ready)
      begin
        req_q  <= 1'b0;
        wait_q <= 1'b1;
      end
      if (got)
        wait_q <= 1'b0;
      if (redirect)
      begin
        // held word is dropped, an in-flight one is discarded later
        out_q <= 1'b0;
        if (busy)
          drop_q <= 1'b1;
        else
        begin
          drop_q <= 1'b0;
          req_q  <= 1'b1;
          pc_q   <= redirect_pc;
        end
      end
      else if (got && drop_q)
      begin
        drop_q <= 1'b0;
        req_q  <= 1'b1;
        pc_q   <= npc_q;
      end
      else if (got)
        out_q <= 1'b1;
      else if (take)
      begin
        out_q <= 1'b0;
        req_q <= 1'b1;
        pc_q  <= pc_q + `ADDR_LEN'(4);
      end
      else if (!req_q && !wait_q && !out_q)
        req_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_in)
  begin
    if (rdy_in && redirect)
      npc_q <= redirect_pc;
    if (rdy_in && got && !drop_q && !redirect)
      inst_q <= mem.rdata;
  end
endmodule

`default_nettype wire

// ==== rtl/decoder.sv ====
// rv32i subset decoder
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module decoder
  import cpu_pkg::*;
(
  input  logic [`DATA_LEN-1:0] inst,
  output decoded_t             dec
);
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  always_comb
  begin
    dec.op  = OP_NOP;
    dec.rd  = inst[11:7];
    dec.rs1 = inst[19:15];
    dec.rs2 = inst[24:20];
    dec.imm = '0;
    case (opcode)
      7'b0110111:
      begin
        dec.op  = OP_LUI;
        dec.imm = {inst[31:12], 12'b0};
      end
      7'b0010011:
      begin
        if (funct3 == 3'b000)
          dec.op = OP_ADDI;
        dec.imm = {{20{inst[31]}}, inst[31:20]};
      end
      7'b0110011:
      begin
        if (funct3 == 3'b000 && funct7 == 7'b0000000)
          dec.op = OP_ADD;
        else if (funct3 == 3'b000 && funct7 == 7'b0100000)
          dec.op = OP_SUB;
      end
      7'b0000011:
      begin
        // word loads only
        if (funct3 == 3'b010)
          dec.op = OP_LW;
        dec.imm = {{20{inst[31]}}, inst[31:20]};
      end
      7'b0100011:
      begin
        if (funct3 == 3'b010)
          dec.op = OP_SW;
        dec.imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      end
      7'b1100011:
      begin
        if (funct3 == 3'b000)
          dec.op = OP_BEQ;
        dec.imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
      end
      default:
        dec.op = OP_NOP;
    endcase
  end
endmodule

`default_nettype wire

// ==== rtl/reg_file.sv ====
// integer register file
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module reg_file
  import cpu_pkg::*;
(
  input  logic                 clk_in,
  input  logic                 rst_in,
  input  logic [`REG_LEN-1:0]  rs1,
  input  logic [`REG_LEN-1:0]  rs2,
  output logic [`DATA_LEN-1:0] rdata1,
  output logic [`DATA_LEN-1:0] rdata2,
  input  logic                 we,
  input  logic [`REG_LEN-1:0]  rd,
  input  logic [`DATA_LEN-1:0] wdata,
  output logic [`DATA_LEN-1:0] dbg
);
  logic [`DATA_LEN-1:0] regs [32];

  assign rdata1 = regs[rs1];
  assign rdata2 = regs[rs2];
  // a0 for the debug port
  assign dbg = regs[10];

  always_ff @(posedge clk_in)
  begin
    if (rst_in)
    begin
      for (int i = 0; i < 32; i++)
        regs[i] <= '0;
    end
    else if (we && rd != '0)
      regs[rd] <= wdata;
  end
endmodule

`default_nettype wire

// ==== rtl/exec_unit.sv ====
// execute and load/store unit
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module exec_unit
  import cpu_pkg::*;
(
  input  logic                 clk_in,
  input  logic                 rst_in,
  input  logic                 rdy_in,
  inst_if.sink                 inst,
  mem_req_if.requester         mem,
  output logic [`REG_LEN-1:0]  rs1,
  output logic [`REG_LEN-1:0]  rs2,
  input  logic [`DATA_LEN-1:0] rdata1,
  input  logic [`DATA_LEN-1:0] rdata2,
  output logic                 we,
  output logic [`REG_LEN-1:0]  rd,
  output logic [`DATA_LEN-1:0] wdata,
  output logic                 redirect,
  output logic [`ADDR_LEN-1:0] redirect_pc
);
  exec_state_e          state;
  decoded_t             dec;
  logic                 take;
  logic                 alu_op;
  logic                 mem_op;
  logic [`DATA_LEN-1:0] alu_res;
  logic                 req_q;
  logic                 wr_q;
  logic [`ADDR_LEN-1:0] addr_q;
  logic [`DATA_LEN-1:0] wdata_q;
  logic [`REG_LEN-1:0]  rd_q;

  decoder u_decoder (.inst(inst.inst), .dec(dec));

  assign take = (state == EX_IDLE) && inst.valid && rdy_in;
  assign inst.ready = take;
  assign rs1 = dec.rs1;
  assign rs2 = dec.rs2;

  assign alu_op = dec.op inside {OP_LUI, OP_ADDI, OP_ADD, OP_SUB};
  assign mem_op = (dec.op == OP_LW) || (dec.op == OP_SW);

  always_comb
  begin
    case (dec.op)
      OP_LUI:  alu_res = dec.imm;
      OP_ADDI: alu_res = rdata1 + dec.imm;
      OP_ADD:  alu_res = rdata1 + rdata2;
      OP_SUB:  alu_res = rdata1 - rdata2;
      default: alu_res = '0;
    endcase
  end

  // alu result on accept, load data on done
  assign we = (take && alu_op) || ((state == EX_MEM) && mem.done && !wr_q);
  assign rd = (state == EX_MEM) ? rd_q : dec.rd;
  assign wdata = (state == EX_MEM) ? mem.rdata : alu_res;

  assign redirect = take && (dec.op == OP_BEQ) && (rdata1 == rdata2);
  assign redirect_pc = inst.pc + dec.imm;

  assign mem.valid = req_q;
  assign mem.addr = addr_q;
  assign mem.wdata = wdata_q;
  assign mem.wr = wr_q;

  always_ff @(posedge clk_in)
  begin
    if (rst_in)
    begin
      state <= EX_IDLE;
      req_q <= 1'b0;
    end
    else if (rdy_in)
    begin
      case (state)
        EX_IDLE:
        begin
          if (take && mem_op)
          begin
            state <= EX_MEM;
            req_q <= 1'b1;
          end
        end
        EX_MEM:
        begin
          if (mem.ready)
            req_q <= 1'b0;
          // halt once the stop write is on the bus
          if (mem.done)
            state <= (wr_q && addr_q == `IO_HALT_ADDR) ? EX_HALT : EX_IDLE;
        end
        default:
          state <= EX_HALT;
      endcase
    end
  end

  always_ff @(posedge clk_in)
  begin
    if (take && mem_op)
    begin
      addr_q  <= rdata1 + dec.imm;
      wdata_q <= rdata2;
      wr_q    <= (dec.op == OP_SW);
      rd_q    <= dec.rd;
    end
  end
endmodule

`default_nettype wire

// ==== rtl/cpu.sv ====
// rv32i core top
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module cpu
  import cpu_pkg::*;
(
  input  logic        clk_in,
  input  logic        rst_in,
  // pauses the whole core when low
  input  logic        rdy_in,
  input  logic [7:0]  mem_din,
  output logic [7:0]  mem_dout,
  output logic [31:0] mem_a,
  output logic        mem_wr,
  input  logic        io_buffer_full,
  output logic [31:0] dbgreg_dout
);
  logic                 redirect;
  logic [`ADDR_LEN-1:0] redirect_pc;
  logic [`REG_LEN-1:0]  rs1;
  logic [`REG_LEN-1:0]  rs2;
  logic [`DATA_LEN-1:0] rdata1;
  logic [`DATA_LEN-1:0] rdata2;
  logic                 we;
  logic [`REG_LEN-1:0]  rd;
  logic [`DATA_LEN-1:0] wdata;

  mem_req_if if_req ();
  mem_req_if ls_req ();
  inst_if    iq ();

  fetcher u_fetcher (
    .clk_in,
    .rst_in,
    .rdy_in,
    .mem(if_req),
    .inst(iq),
    .redirect,
    .redirect_pc
  );

  exec_unit u_exec (
    .clk_in,
    .rst_in,
    .rdy_in,
    .inst(iq),
    .mem(ls_req),
    .rs1,
    .rs2,
    .rdata1,
    .rdata2,
    .we,
    .rd,
    .wdata,
    .redirect,
    .redirect_pc
  );

  reg_file u_regs (
    .clk_in,
    .rst_in,
    .rs1,
    .rs2,
    .rdata1,
    .rdata2,
    .we,
    .rd,
    .wdata,
    .dbg(dbgreg_dout)
  );

  mem_ctrl u_mem_ctrl (
    .clk_in,
    .rst_in,
    .rdy_in,
    .if_port(if_req),
    .ls_port(ls_req),
    .mem_din,
    .mem_dout,
    .mem_a,
    .mem_wr,
    .io_buffer_full
  );
endmodule

`default_nettype wire

// ==== dv/cpu_checker.sv ====
// memory bus assertions for the core
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module cpu_checker (
  input logic        clk_in,
  input logic        rst_in,
  input logic [31:0] mem_a,
  input logic        mem_wr,
  input logic        io_buffer_full
);
  int unsigned fails = 0;

  // write strobe is quiet right after reset
  wr_low_after_reset: assert property (@(posedge clk_in) rst_in |=> !mem_wr)
  else
  begin
    $error("mem_wr is high in the cycle after reset");
    fails++;
  end

  // RAM below 128K, otherwise the I/O page
  addr_in_map: assert property (@(posedge clk_in) disable iff (rst_in)
    (mem_a < 32'h0002_0000) || (mem_a[17:16] == 2'b11))
  else
  begin
    $error("mem_a %h is outside RAM and I/O space", mem_a);
    fails++;
  end

  no_write_when_full: assert property (@(posedge clk_in) disable iff (rst_in)
    !(mem_wr && (mem_a == `IO_OUT_ADDR) && io_buffer_full))
  else
  begin
    $error("output byte written while io_buffer_full is high");
    fails++;
  end
endmodule

bind cpu cpu_checker u_checker (
  .clk_in,
  .rst_in,
  .mem_a,
  .mem_wr,
  .io_buffer_full
);

`default_nettype wire

// ==== dv/tb_cpu.sv ====
// rv32i core testbench
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module tb_cpu;
  localparam int RAM_BYTES = 'h2_0000;
  // generous bound over all six programs
  localparam int TIMEOUT_CYCLES = 6000;

  logic        clk_in;
  logic        rst_in;
  logic        rdy_in;
  logic [7:0]  mem_din;
  logic [7:0]  mem_dout;
  logic [31:0] mem_a;
  logic        mem_wr;
  logic        io_buffer_full;
  logic [31:0] dbgreg_dout;

  logic [7:0]  ram [RAM_BYTES];
  logic [31:0] wr_addrs [$];
  logic [7:0]  wr_bytes [$];
  logic [7:0]  io_bytes [$];
  logic        halt_seen;
  int          post_halt_writes;
  int          hold_errors;
  logic        pause_on;
  logic        io_on;
  logic [31:0] held_a;
  logic        held_wr;
  logic [31:0] rd_addr;
  logic [31:0] load_pc;
  int          checks;
  int          errors;
  int          cycles;

  cpu dut0 (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .rdy_in(rdy_in),
    .mem_din(mem_din),
    .mem_dout(mem_dout),
    .mem_a(mem_a),
    .mem_wr(mem_wr),
    .io_buffer_full(io_buffer_full),
    .dbgreg_dout(dbgreg_dout)
  );

  initial
  begin
    clk_in = 1'b0;
    forever
      #50 clk_in = ~clk_in;
  end

  // environment side of the bus, changes on the falling edge
  initial
  begin
    void'($urandom(58));
    rdy_in = 1'b1;
    io_buffer_full = 1'b0;
    mem_din = 8'h00;
    rd_addr = '0;
    forever
    begin
      @(negedge clk_in);
      if (!rst_in && !rdy_in && (mem_a !== held_a || mem_wr !== held_wr))
      begin
        hold_errors++;
        $display("mem_a or mem_wr changed while rdy_in was low at %0t", $time);
      end
      held_a = mem_a;
      held_wr = mem_wr;
      // read byte lags its address by one cycle
      mem_din = (rd_addr < RAM_BYTES) ? ram[rd_addr[16:0]] : 8'h00;
      rd_addr = mem_a;
      rdy_in = pause_on ? ($urandom_range(3) != 0) : 1'b1;
      io_buffer_full = io_on ? ($urandom_range(2) == 0) : 1'b0;
    end
  end

  // writes only land while the bus is not paused
  always @(posedge clk_in)
  begin
    if (rdy_in && mem_wr)
    begin
      if (halt_seen && (mem_a < `IO_HALT_ADDR || mem_a > `IO_HALT_ADDR + 3))
        post_halt_writes++;
      if (mem_a < RAM_BYTES)
      begin
        ram[mem_a[16:0]] = mem_dout;
        wr_addrs.push_back(mem_a);
        wr_bytes.push_back(mem_dout);
      end
      else if (mem_a == `IO_OUT_ADDR)
        io_bytes.push_back(mem_dout);
      else if (mem_a == `IO_HALT_ADDR)
        halt_seen = 1'b1;
    end
  end

  initial
  begin
    for (cycles = 0; cycles < TIMEOUT_CYCLES; cycles++)
      @(posedge clk_in);
    $display("timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Verification failed");
    $finish;
  end

  function automatic logic [31:0] sext12(input logic [11:0] imm);
    return {{20{imm[11]}}, imm};
  endfunction

  function automatic logic [31:0] lui_inst(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic logic [31:0] i_type(input logic [6:0] opc, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] addi_inst(input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [11:0] imm);
    return i_type(7'b0010011, 3'b000, rd, rs1, imm);
  endfunction

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rd,
                                         input logic [4:0] rs1, input logic [4:0] rs2);
    return {f7, rs2, rs1, 3'b000, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] store_inst(input logic [4:0] rs2, input logic [4:0] rs1,
                                             input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] branch_inst(input logic [4:0] rs1, input logic [4:0] rs2,
                                              input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] read_word(input logic [31:0] addr);
    return {ram[addr + 3], ram[addr + 2], ram[addr + 1], ram[addr]};
  endfunction

  task automatic put_word(input logic [31:0] addr, input logic [31:0] data);
    {ram[addr + 3], ram[addr + 2], ram[addr + 1], ram[addr]} = data;
  endtask

  task automatic clear_program();
    for (int a = 0; a < RAM_BYTES; a++)
      ram[a] = 8'h00;
    load_pc = `RESET_PC;
  endtask

  task automatic emit(input logic [31:0] inst);
    put_word(load_pc, inst);
    load_pc += 4;
  endtask

  // x5 points at the I/O page, a word store to +4 stops the core
  task automatic add_halt();
    emit(lui_inst(5'd5, 20'h00030));
    emit(store_inst(5'd0, 5'd5, 12'h004));
  endtask

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic run_program(input logic pause, input logic io_noise);
    @(negedge clk_in);
    rst_in = 1'b1;
    repeat (16)
      @(negedge clk_in);
    wr_addrs.delete();
    wr_bytes.delete();
    io_bytes.delete();
    halt_seen = 1'b0;
    post_halt_writes = 0;
    hold_errors = 0;
    rst_in = 1'b0;
    @(posedge clk_in);
    pause_on = pause;
    io_on = io_noise;
    while (!halt_seen)
      @(negedge clk_in);
    // quiet window after the stop write
    repeat (50)
      @(negedge clk_in);
    @(posedge clk_in);
    pause_on = 1'b0;
    io_on = 1'b0;
    @(negedge clk_in);
  endtask

  task automatic load_arith();
    clear_program();
    emit(lui_inst(5'd1, 20'h12345));
    emit(addi_inst(5'd2, 5'd1, 12'h678));
    emit(addi_inst(5'd3, 5'd0, 12'hffb));
    emit(r_type(7'h00, 5'd4, 5'd2, 5'd3));
    emit(r_type(7'h20, 5'd10, 5'd3, 5'd2));
    emit(store_inst(5'd1, 5'd0, 12'h100));
    emit(store_inst(5'd2, 5'd0, 12'h104));
    emit(store_inst(5'd3, 5'd0, 12'h108));
    emit(store_inst(5'd4, 5'd0, 12'h10c));
    emit(store_inst(5'd10, 5'd0, 12'h110));
    add_halt();
  endtask

  task automatic check_arith(input string name);
    logic [31:0] x1;
    logic [31:0] x2;
    logic [31:0] x3;
    logic [31:0] x4;
    logic [31:0] x10;
    x1 = 32'h12345 << 12;
    x2 = x1 + sext12(12'h678);
    x3 = 32'h0 + sext12(12'hffb);
    x4 = x2 + x3;
    x10 = x3 - x2;
    check({name, " lui"}, x1, read_word(32'h100));
    check({name, " addi"}, x2, read_word(32'h104));
    check({name, " addi neg"}, x3, read_word(32'h108));
    check({name, " add"}, x4, read_word(32'h10c));
    check({name, " sub"}, x10, read_word(32'h110));
    check({name, " dbgreg"}, x10, dbgreg_dout);
  endtask

  task automatic test_arith();
    load_arith();
    run_program(1'b0, 1'b0);
    check_arith("arith");
  endtask

  task automatic test_load_store();
    logic [31:0] expected;
    clear_program();
    emit(i_type(7'b0000011, 3'b010, 5'd6, 5'd0, 12'h200));
    emit(addi_inst(5'd6, 5'd6, 12'h011));
    emit(store_inst(5'd6, 5'd0, 12'h204));
    add_halt();
    put_word(32'h200, 32'ha1b2_c3d4);
    expected = 32'ha1b2_c3d4 + sext12(12'h011);
    run_program(1'b0, 1'b0);
    check("load/store write count", 4, wr_addrs.size());
    for (int i = 0; i < wr_addrs.size() && i < 4; i++)
    begin
      check("load/store addr", 32'h204 + i, wr_addrs[i]);
      check("load/store byte", expected[8*i +: 8], wr_bytes[i]);
    end
  endtask

  task automatic test_branch();
    clear_program();
    emit(addi_inst(5'd1, 5'd0, 12'h007));
    emit(addi_inst(5'd2, 5'd0, 12'h007));
    emit(addi_inst(5'd3, 5'd0, 12'h009));
    // taken, jumps over the next store
    emit(branch_inst(5'd1, 5'd2, 13'd8));
    emit(store_inst(5'd1, 5'd0, 12'h300));
    emit(branch_inst(5'd1, 5'd3, 13'd8));
    emit(store_inst(5'd3, 5'd0, 12'h304));
    add_halt();
    run_program(1'b0, 1'b0);
    check("branch write count", 4, wr_addrs.size());
    for (int i = 0; i < wr_addrs.size(); i++)
      check("branch addr", 32'h304 + i, wr_addrs[i]);
    check("branch skipped store", 32'h0, read_word(32'h300));
    check("branch fall through", sext12(12'h009), read_word(32'h304));
  endtask

  task automatic test_io();
    logic [7:0] sent [3];
    sent = '{8'h48, 8'h69, 8'h21};
    clear_program();
    emit(lui_inst(5'd5, 20'h00030));
    for (int i = 0; i < 3; i++)
    begin
      emit(addi_inst(5'd1, 5'd0, {4'h0, sent[i]}));
      emit(store_inst(5'd1, 5'd5, 12'h000));
    end
    add_halt();
    run_program(1'b0, 1'b1);
    check("io byte count", 3, io_bytes.size());
    for (int i = 0; i < io_bytes.size() && i < 3; i++)
      check("io byte", sent[i], io_bytes[i]);
  endtask

  task automatic test_pause();
    load_arith();
    run_program(1'b1, 1'b0);
    check_arith("pause");
    check("pause bus hold", 0, hold_errors);
  endtask

  task automatic test_halt();
    clear_program();
    emit(addi_inst(5'd1, 5'd0, 12'h055));
    add_halt();
    // must never run
    emit(store_inst(5'd1, 5'd0, 12'h400));
    emit(store_inst(5'd1, 5'd5, 12'h000));
    run_program(1'b0, 1'b0);
    check("halt late writes", 0, post_halt_writes);
    check("halt ram untouched", 32'h0, read_word(32'h400));
    check("halt io untouched", 0, io_bytes.size());
  endtask

  initial
  begin
    rst_in = 1'b1;
    halt_seen = 1'b0;
    post_halt_writes = 0;
    hold_errors = 0;
    pause_on = 1'b0;
    io_on = 1'b0;
    checks = 0;
    errors = 0;
    test_arith();
    test_load_store();
    test_branch();
    test_io();
    test_pause();
    test_halt();
    $display("checks %0d, failed %0d, assertion failures %0d",
             checks, errors, dut0.u_checker.fails);
    if (errors == 0 && dut0.u_checker.fails == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end
endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+rtl
rtl/cpu_pkg.sv
rtl/mem_req_if.sv
rtl/inst_if.sv
rtl/mem_ctrl.sv
rtl/fetcher.sv
rtl/decoder.sv
rtl/reg_file.sv
rtl/exec_unit.sv
rtl/cpu.sv
dv/cpu_checker.sv
dv/tb_cpu.sv

// ==== Bender.yml ====
package:
  name: rv32i_core

export_include_dirs:
  - rtl

sources:
  - rtl/cpu_pkg.sv
  - rtl/mem_req_if.sv
  - rtl/inst_if.sv
  - rtl/mem_ctrl.sv
  - rtl/fetcher.sv
  - rtl/decoder.sv
  - rtl/reg_file.sv
  - rtl/exec_unit.sv
  - rtl/cpu.sv
  - target: simulation
    files:
      - dv/cpu_checker.sv
      - dv/tb_cpu.sv
